//--- hdl/lsuPkg.sv
package lsuPkg;

    // --------------------
    // Basic types
    // --------------------

    typedef logic [31:0] Data;         // Address, register value or memory word
    typedef logic [4:0]  RegIdx;       // Register number
    typedef logic [2:0]  Funct3;       // Load/store funct3 field

    typedef enum logic [1:0] {
        ACC_BYTE,                      // 8 bit access
        ACC_HALF,                      // 16 bit access
        ACC_WORD                       // 32 bit access
    } DataAccess;

    typedef enum logic [1:0] {
        ERR_NONE,                      // Access completed
        ERR_ILLEGAL,                   // Undefined funct3
        ERR_ALIGN                      // Misaligned address
    } ErrCode;

    // --------------------
    // funct3 codes
    // --------------------

    // Loads
    localparam Funct3 F3_LB  = 3'd0;
    localparam Funct3 F3_LH  = 3'd1;
    localparam Funct3 F3_LW  = 3'd2;
    localparam Funct3 F3_LBU = 3'd4;
    localparam Funct3 F3_LHU = 3'd5;

    // Stores, 3 and above undefined
    localparam Funct3 F3_SB  = 3'd0;
    localparam Funct3 F3_SH  = 3'd1;
    localparam Funct3 F3_SW  = 3'd2;

endpackage

//--- hdl/dataRam.sv
`timescale 1ns/1ps

module dataRam #(
    parameter int ADDR_WIDTH = 10)                 // Byte address bits
(
    input  logic                  i_clock,         // Clock
    input  logic [3:0]            i_wrStrobe,      // One bit per byte lane
    input  logic                  i_rdEnable,
    input  logic [ADDR_WIDTH-3:0] i_wordAddr,
    input  lsuPkg::Data           i_wrData,
    output lsuPkg::Data           o_rdData);       // Valid one cycle after read

    localparam int WORDS = 2 ** (ADDR_WIDTH - 2);

    lsuPkg::Data mem [WORDS] = '{default: '0};     // Starts cleared

    always_ff @(posedge i_clock) begin
        for (int b = 0; b < 4; b++) begin
            if (i_wrStrobe[b])
                mem[i_wordAddr][8*b +: 8] <= i_wrData[8*b +: 8];
        end
        if (i_rdEnable)
            o_rdData <= mem[i_wordAddr];
    end

endmodule

//--- hdl/dataMemoryAdapter.sv
`timescale 1ns/1ps

module dataMemoryAdapter #(
    parameter int ADDR_WIDTH = 10)
(
    input  logic                  i_clock,       // Clock
    input  logic                  i_arstN,       // Async reset, active low
    input  logic [ADDR_WIDTH-1:0] i_addr,        // Byte address
    input  logic                  i_unsigned,    // Zero extend load
    input  lsuPkg::DataAccess     i_access,      // Access size
    input  logic                  i_wrEnable,
    input  logic                  i_rdEnable,
    input  lsuPkg::Data           i_wrData,      // Store data, low aligned
    output lsuPkg::Data           o_rdData);     // Load data, extended

    logic [3:0]        wrStrobe;
    lsuPkg::Data       wrLanes;
    lsuPkg::Data       ramData;
    lsuPkg::Data       lane;
    lsuPkg::DataAccess rdAccess;
    logic [1:0]        rdOffset;
    logic              rdUnsigned;

    // --------------------
    // Store steering
    // --------------------

    always_comb begin
        case (i_access)
            lsuPkg::ACC_BYTE: begin
                wrLanes  = {4{i_wrData[7:0]}};
                wrStrobe = 4'b0001 << i_addr[1:0];
            end
            lsuPkg::ACC_HALF: begin
                wrLanes  = {2{i_wrData[15:0]}};
                wrStrobe = 4'b0011 << {i_addr[1], 1'b0};
            end
            default: begin
                wrLanes  = i_wrData;
                wrStrobe = 4'b1111;
            end
        endcase
        if (!i_wrEnable)
            wrStrobe = 4'b0000;                      // No write this cycle
    end

    dataRam #(
        .ADDR_WIDTH (ADDR_WIDTH))
    ram (
        .i_clock    (i_clock),
        .i_wrStrobe (wrStrobe),
        .i_rdEnable (i_rdEnable),
        .i_wordAddr (i_addr[ADDR_WIDTH-1:2]),
        .i_wrData   (wrLanes),
        .o_rdData   (ramData));

    // --------------------
    // Load extraction
    // --------------------

    always_ff @(posedge i_clock or negedge i_arstN) begin
        if (!i_arstN) begin
            rdAccess   <= lsuPkg::ACC_WORD;
            rdOffset   <= 2'b00;
            rdUnsigned <= 1'b0;
        end else if (i_rdEnable) begin
            rdAccess   <= i_access;                  // Held until next load
            rdOffset   <= i_addr[1:0];
            rdUnsigned <= i_unsigned;
        end
    end

    assign lane = ramData >> {rdOffset, 3'b000};     // Selected lane to bit 0

    always_comb begin
        case (rdAccess)
            lsuPkg::ACC_BYTE: o_rdData = {{24{~rdUnsigned & lane[7]}}, lane[7:0]};
            lsuPkg::ACC_HALF: o_rdData = {{16{~rdUnsigned & lane[15]}}, lane[15:0]};
            default:          o_rdData = lane;
        endcase
    end

endmodule

//--- hdl/stageMem.sv
`timescale 1ns/1ps

module stageMem #(
    parameter int ADDR_WIDTH = 10)             // RAM byte address bits
(
    input  logic              i_clock,         // Clock
    input  logic              i_arstN,         // Active low async reset
    input  logic              i_isValid,       // Valid operation
    input  lsuPkg::Data       i_addr,          // Byte address
    input  lsuPkg::Data       i_dataB,         // Store data
    input  logic              i_memWrEnable,
    input  logic              i_memRdEnable,
    input  lsuPkg::DataAccess i_memAccess,
    input  logic              i_memUnsigned,
    input  lsuPkg::RegIdx     i_rd,
    input  lsuPkg::ErrCode    i_err,
    output logic              o_valid,         // Aligned with o_rdData
    output lsuPkg::Data       o_addr,
    output lsuPkg::RegIdx     o_rd,
    output logic              o_isLoad,
    output lsuPkg::ErrCode    o_err,
    output lsuPkg::Data       o_rdData);       // Extended load data

    logic wrEnable;
    logic rdEnable;

    assign wrEnable = i_memWrEnable & i_isValid;   // Only valid ops reach the RAM
    assign rdEnable = i_memRdEnable & i_isValid;

    // --------------------
    // Data memory
    // --------------------

    dataMemoryAdapter #(
        .ADDR_WIDTH (ADDR_WIDTH))
    memAdapter (
        .i_clock    (i_clock),
        .i_arstN    (i_arstN),
        .i_addr     (i_addr[ADDR_WIDTH-1:0]),
        .i_unsigned (i_memUnsigned),
        .i_access   (i_memAccess),
        .i_wrEnable (wrEnable),
        .i_rdEnable (rdEnable),
        .i_wrData   (i_dataB),
        .o_rdData   (o_rdData));

    // Controls follow the RAM read by one cycle
    always_ff @(posedge i_clock or negedge i_arstN) begin
        if (!i_arstN)
            o_valid <= 1'b0;
        else
            o_valid <= i_isValid;
    end

    always_ff @(posedge i_clock) begin
        o_addr   <= i_addr;
        o_rd     <= i_rd;
        o_err    <= i_err;
        o_isLoad <= rdEnable;
    end

endmodule

//--- hdl/lsuDecode.sv
`timescale 1ns/1ps

module lsuDecode (
    input  logic              i_clock,       // Clock
    input  logic              i_arstN,       // Async reset, active low
    input  logic              i_valid,       // Request accepted
    input  lsuPkg::Funct3     i_funct3,      // Access code
    input  logic              i_isStore,     // Store request
    input  lsuPkg::Data       i_base,        // Base register value
    input  lsuPkg::Data       i_offset,      // Sign extended offset
    input  lsuPkg::Data       i_storeData,   // Data to store
    input  lsuPkg::RegIdx     i_rd,          // Destination register
    output logic              o_valid,
    output lsuPkg::Data       o_base,
    output lsuPkg::Data       o_offset,
    output lsuPkg::Data       o_storeData,
    output lsuPkg::RegIdx     o_rd,
    output lsuPkg::DataAccess o_access,      // Access size
    output logic              o_unsigned,    // Zero extend on load
    output logic              o_rdEnable,    // Memory read
    output logic              o_wrEnable,    // Memory write
    output logic              o_illegal);    // Undefined funct3

    lsuPkg::DataAccess access;
    logic              isUnsigned;
    logic              illegal;

    always_comb begin
        access     = lsuPkg::ACC_WORD;
        isUnsigned = 1'b0;
        illegal    = 1'b0;
        if (i_isStore) begin
            case (i_funct3)
                lsuPkg::F3_SB: access = lsuPkg::ACC_BYTE;
                lsuPkg::F3_SH: access = lsuPkg::ACC_HALF;
                lsuPkg::F3_SW: access = lsuPkg::ACC_WORD;
                default:       illegal = 1'b1;       // Codes 3..7
            endcase
        end else begin
            case (i_funct3)
                lsuPkg::F3_LB:  access = lsuPkg::ACC_BYTE;
                lsuPkg::F3_LH:  access = lsuPkg::ACC_HALF;
                lsuPkg::F3_LW:  access = lsuPkg::ACC_WORD;
                lsuPkg::F3_LBU: begin
                    access     = lsuPkg::ACC_BYTE;
                    isUnsigned = 1'b1;
                end
                lsuPkg::F3_LHU: begin
                    access     = lsuPkg::ACC_HALF;
                    isUnsigned = 1'b1;
                end
                default:        illegal = 1'b1;      // Codes 3, 6 and 7
            endcase
        end
    end

    always_ff @(posedge i_clock or negedge i_arstN) begin
        if (!i_arstN)
            o_valid <= 1'b0;
        else
            o_valid <= i_valid;
    end

    always_ff @(posedge i_clock) begin
        o_base      <= i_base;
        o_offset    <= i_offset;
        o_storeData <= i_storeData;
        o_rd        <= i_rd;
        o_access    <= access;
        o_unsigned  <= isUnsigned;
        o_illegal   <= illegal;
        o_wrEnable  <= i_isStore & ~illegal;   // No access on undefined code
        o_rdEnable  <= ~i_isStore & ~illegal;
    end

endmodule

//--- hdl/lsuExecute.sv
`timescale 1ns/1ps

module lsuExecute (
    input  logic              i_clock,       // Clock
    input  logic              i_arstN,       // Async reset, active low
    input  logic              i_valid,
    input  lsuPkg::Data       i_base,
    input  lsuPkg::Data       i_offset,
    input  lsuPkg::Data       i_storeData,
    input  lsuPkg::RegIdx     i_rd,
    input  lsuPkg::DataAccess i_access,
    input  logic              i_unsigned,
    input  logic              i_rdEnable,
    input  logic              i_wrEnable,
    input  logic              i_illegal,
    output logic              o_valid,
    output lsuPkg::Data       o_addr,        // Byte address
    output lsuPkg::Data       o_storeData,
    output lsuPkg::RegIdx     o_rd,
    output lsuPkg::DataAccess o_access,
    output logic              o_unsigned,
    output logic              o_rdEnable,
    output logic              o_wrEnable,
    output lsuPkg::ErrCode    o_err);        // Access error

    lsuPkg::Data    addr;
    logic           misaligned;
    lsuPkg::ErrCode err;

    assign addr       = i_base + i_offset;
    assign misaligned = ((i_access == lsuPkg::ACC_HALF) && addr[0]) ||
                        ((i_access == lsuPkg::ACC_WORD) && (addr[1:0] != 2'b00));
    assign err        = i_illegal  ? lsuPkg::ERR_ILLEGAL :   // Illegal wins
                        misaligned ? lsuPkg::ERR_ALIGN : lsuPkg::ERR_NONE;

    always_ff @(posedge i_clock or negedge i_arstN) begin
        if (!i_arstN)
            o_valid <= 1'b0;
        else
            o_valid <= i_valid;
    end

    always_ff @(posedge i_clock) begin
        o_addr      <= addr;
        o_storeData <= i_storeData;
        o_rd        <= i_rd;
        o_access    <= i_access;
        o_unsigned  <= i_unsigned;
        o_err       <= err;
        o_rdEnable  <= i_rdEnable & (err == lsuPkg::ERR_NONE);  // Faulty access never
        o_wrEnable  <= i_wrEnable & (err == lsuPkg::ERR_NONE);  // reaches the RAM
    end

endmodule

//--- hdl/lsuResult.sv
`timescale 1ns/1ps

module lsuResult #(
    parameter int CREDITS = 4)                     // Queue depth
(
    input  logic           i_clock,                // Clock
    input  logic           i_arstN,                // Async reset, active low
    input  logic           i_valid,                // Result from memory stage
    input  lsuPkg::RegIdx  i_rd,
    input  logic           i_isLoad,
    input  lsuPkg::Data    i_addr,
    input  lsuPkg::Data    i_memData,
    input  lsuPkg::ErrCode i_err,
    input  logic           i_resCredit,            // Consumer returns one credit
    output logic           o_credit,               // Producer gets one credit
    output logic           o_resValid,
    output lsuPkg::RegIdx  o_resRd,
    output lsuPkg::Data    o_resData,
    output logic           o_resWrEn,
    output lsuPkg::ErrCode o_resErr);

    localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CNT_W = $clog2(CREDITS + 1);

    lsuPkg::RegIdx  qRd   [CREDITS];
    lsuPkg::Data    qData [CREDITS];
    logic           qWrEn [CREDITS];
    lsuPkg::ErrCode qErr  [CREDITS];

    logic [PTR_W-1:0] wrPtr, rdPtr;
    logic [CNT_W-1:0] count;                       // Entries in queue
    logic [CNT_W-1:0] outCredits;                  // Consumer credits held
    logic             deq;

    assign deq        = (count != '0) && (outCredits != '0);
    assign o_resValid = deq;
    assign o_resRd    = qRd[rdPtr];
    assign o_resData  = qData[rdPtr];
    assign o_resWrEn  = qWrEn[rdPtr];
    assign o_resErr   = qErr[rdPtr];

    // Write-back data select and queue storage
    always_ff @(posedge i_clock) begin
        if (i_valid) begin
            qRd[wrPtr]   <= i_rd;
            qData[wrPtr] <= i_isLoad ? i_memData : i_addr;
            qWrEn[wrPtr] <= i_isLoad & (i_err == lsuPkg::ERR_NONE);
            qErr[wrPtr]  <= i_err;
        end
    end

    // --------------------
    // Pointers and credits
    // --------------------

    always_ff @(posedge i_clock or negedge i_arstN) begin
        if (!i_arstN) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            outCredits <= CNT_W'(CREDITS);
            o_credit   <= 1'b0;
        end else begin
            if (i_valid)
                wrPtr <= (wrPtr == PTR_W'(CREDITS - 1)) ? '0 : wrPtr + 1'b1;
            if (deq)
                rdPtr <= (rdPtr == PTR_W'(CREDITS - 1)) ? '0 : rdPtr + 1'b1;
            count      <= count + CNT_W'(i_valid) - CNT_W'(deq);
            outCredits <= outCredits + CNT_W'(i_resCredit) - CNT_W'(deq);
            o_credit   <= deq;                     // Slot freed last cycle
        end
    end

endmodule

//--- hdl/lsuTop.sv
`timescale 1ns/1ps

module lsuTop #(
    parameter int ADDR_WIDTH = 10,                 // RAM byte address bits
    parameter int CREDITS    = 4)                  // Credits at each end
(
    input  logic           i_clock,                // Clock
    input  logic           i_arstN,                // Async reset, active low
    input  logic           i_valid,                // Request, spends a credit
    input  lsuPkg::Funct3  i_funct3,
    input  logic           i_isStore,
    input  lsuPkg::Data    i_base,
    input  lsuPkg::Data    i_offset,
    input  lsuPkg::Data    i_storeData,
    input  lsuPkg::RegIdx  i_rd,
    output logic           o_credit,               // Request credit return
    input  logic           i_resCredit,            // Result credit return
    output logic           o_resValid,
    output lsuPkg::RegIdx  o_resRd,
    output lsuPkg::Data    o_resData,
    output logic           o_resWrEn,
    output lsuPkg::ErrCode o_resErr);

    // --------------------
    // Decode to execute
    // --------------------

    logic              decValid, decUnsigned, decRdEn, decWrEn, decIllegal;
    lsuPkg::Data       decBase, decOffset, decStoreData;
    lsuPkg::RegIdx     decRd;
    lsuPkg::DataAccess decAccess;

    lsuDecode decode (
        .i_clock     (i_clock),      .i_arstN    (i_arstN),
        .i_valid     (i_valid),      .i_funct3   (i_funct3),
        .i_isStore   (i_isStore),    .i_base     (i_base),
        .i_offset    (i_offset),     .i_storeData(i_storeData),
        .i_rd        (i_rd),         .o_valid    (decValid),
        .o_base      (decBase),      .o_offset   (decOffset),
        .o_storeData (decStoreData), .o_rd       (decRd),
        .o_access    (decAccess),    .o_unsigned (decUnsigned),
        .o_rdEnable  (decRdEn),      .o_wrEnable (decWrEn),
        .o_illegal   (decIllegal));

    // --------------------
    // Execute to memory
    // --------------------

    logic              exeValid, exeUnsigned, exeRdEn, exeWrEn;
    lsuPkg::Data       exeAddr, exeStoreData;
    lsuPkg::RegIdx     exeRd;
    lsuPkg::DataAccess exeAccess;
    lsuPkg::ErrCode    exeErr;

    lsuExecute execute (
        .i_clock     (i_clock),      .i_arstN    (i_arstN),
        .i_valid     (decValid),     .i_base     (decBase),
        .i_offset    (decOffset),    .i_storeData(decStoreData),
        .i_rd        (decRd),        .i_access   (decAccess),
        .i_unsigned  (decUnsigned),  .i_rdEnable (decRdEn),
        .i_wrEnable  (decWrEn),      .i_illegal  (decIllegal),
        .o_valid     (exeValid),     .o_addr     (exeAddr),
        .o_storeData (exeStoreData), .o_rd       (exeRd),
        .o_access    (exeAccess),    .o_unsigned (exeUnsigned),
        .o_rdEnable  (exeRdEn),      .o_wrEnable (exeWrEn),
        .o_err       (exeErr));

    // --------------------
    // Memory to result
    // --------------------

    logic           memValid, memIsLoad;
    lsuPkg::Data    memAddr, memRdData;
    lsuPkg::RegIdx  memRd;
    lsuPkg::ErrCode memErr;

    stageMem #(
        .ADDR_WIDTH (ADDR_WIDTH))
    memStage (
        .i_clock       (i_clock),     .i_arstN       (i_arstN),
        .i_isValid     (exeValid),    .i_addr        (exeAddr),
        .i_dataB       (exeStoreData),.i_memWrEnable (exeWrEn),
        .i_memRdEnable (exeRdEn),     .i_memAccess   (exeAccess),
        .i_memUnsigned (exeUnsigned), .i_rd          (exeRd),
        .i_err         (exeErr),      .o_valid       (memValid),
        .o_addr        (memAddr),     .o_rd          (memRd),
        .o_isLoad      (memIsLoad),   .o_err         (memErr),
        .o_rdData      (memRdData));

    lsuResult #(
        .CREDITS (CREDITS))
    result (
        .i_clock     (i_clock),     .i_arstN    (i_arstN),
        .i_valid     (memValid),    .i_rd       (memRd),
        .i_isLoad    (memIsLoad),   .i_addr     (memAddr),
        .i_memData   (memRdData),   .i_err      (memErr),
        .i_resCredit (i_resCredit), .o_credit   (o_credit),
        .o_resValid  (o_resValid),  .o_resRd    (o_resRd),
        .o_resData   (o_resData),   .o_resWrEn  (o_resWrEn),
        .o_resErr    (o_resErr));

endmodule

//--- bench/lsuTb.sv
`timescale 1ns/1ps

module lsuTb;

    localparam int ADDR_WIDTH = 10;
    localparam int CREDITS    = 4;
    localparam int NREQ       = 300;                 // Requests in the run
    localparam int PERIOD     = 20;                  // ns
    localparam int MEM_BYTES  = 2 ** ADDR_WIDTH;

    typedef struct packed {
        lsuPkg::RegIdx  rd;
        lsuPkg::Data    data;
        logic           wrEn;
        lsuPkg::ErrCode err;
    } Expected;

    logic           clock, arstN, reqValid, isStore, credit, resCredit, resValid, resWrEn;
    lsuPkg::Funct3  funct3;
    lsuPkg::Data    base, offset, storeData, resData;
    lsuPkg::RegIdx  rd, resRd;
    lsuPkg::ErrCode resErr;

    logic [31:0] rngState = 32'd47190;
    logic [7:0]  shadow [MEM_BYTES];                 // Model of the RAM bytes
    Expected     expQ [$];                           // Expected results in request order
    int          prodCredits  = CREDITS;             // Request credits held
    int          outCredits   = CREDITS;             // Result credits the DUT holds
    int          owed         = 0;                   // Results not yet paid back
    int          issued       = 0;
    int          received     = 0;
    int          creditPulses = 0;
    int          mismatches   = 0;
    int          otherErrors  = 0;

    lsuTop #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .CREDITS    (CREDITS))
    i_lsuTop (
        .i_clock     (clock),     .i_arstN     (arstN),
        .i_valid     (reqValid),  .i_funct3    (funct3),
        .i_isStore   (isStore),   .i_base      (base),
        .i_offset    (offset),    .i_storeData (storeData),
        .i_rd        (rd),        .o_credit    (credit),
        .i_resCredit (resCredit), .o_resValid  (resValid),
        .o_resRd     (resRd),     .o_resData   (resData),
        .o_resWrEn   (resWrEn),   .o_resErr    (resErr));

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    initial begin
        #((NREQ * 20 + 200) * PERIOD);               // Generous bound on the run
        $display("Timeout: only %0d of %0d results arrived", received, NREQ);
        $display("Verification failed");
        $finish;
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    // --------------------
    // Request and model
    // --------------------

    task automatic issueRequest();
        logic [31:0]           r;
        logic [31:0]           addr;
        logic [31:0]           word;
        logic [ADDR_WIDTH-1:0] a;
        int                    k;
        int                    size;
        logic                  illegal;
        logic                  misaligned;
        Expected               e;
        r = nextRand();
        k = int'(r[28:26] % 5);
        isStore = r[31];
        if (r[30:29] == 2'b00)
            funct3 = r[28:26];                       // Any code including undefined ones
        else if (isStore)
            funct3 = 3'(k % 3);
        else
            funct3 = 3'((k < 3) ? k : k + 1);        // Skip code 3
        base   = 32'(64 + 4 * r[20:17]);             // Word aligned small window
        offset = {{28{r[15]}}, r[15:12]};            // -8..7
        if (r[16])
            offset[1:0] = 2'b00;                     // Often keep alignment
        rd        = r[11:7];
        storeData = nextRand();
        reqValid  = 1'b1;

        illegal    = isStore ? (funct3 >= 3'd3) : (funct3 == 3'd3 || funct3 >= 3'd6);
        size       = int'(funct3[1:0]);              // 0 byte, 1 half, 2 word
        addr       = base + offset;
        misaligned = (size == 1 && addr[0]) || (size == 2 && addr[1:0] != 2'b00);
        a          = addr[ADDR_WIDTH-1:0];
        e.rd       = rd;
        e.data     = addr;                           // Stores and faults return the address
        e.wrEn     = 1'b0;
        e.err      = illegal ? lsuPkg::ERR_ILLEGAL :
                     misaligned ? lsuPkg::ERR_ALIGN : lsuPkg::ERR_NONE;
        if (e.err == lsuPkg::ERR_NONE && isStore) begin
            for (int i = 0; i < (1 << size); i++)
                shadow[a + i] = storeData[8*i +: 8];
        end else if (e.err == lsuPkg::ERR_NONE) begin
            word = '0;
            for (int i = 0; i < (1 << size); i++)
                word[8*i +: 8] = shadow[a + i];      // Little endian
            if (!funct3[2] && size == 0)
                word = {{24{word[7]}}, word[7:0]};
            if (!funct3[2] && size == 1)
                word = {{16{word[15]}}, word[15:0]};
            e.data = word;
            e.wrEn = 1'b1;
        end
        expQ.push_back(e);
    endtask

    // --------------------
    // Output checks
    // --------------------

    task automatic checkOutputs();
        Expected e;
        if (credit) begin
            creditPulses++;
            prodCredits++;
            if (prodCredits > CREDITS) begin
                otherErrors++;
                $display("Request credit returned at %0t with no request outstanding", $time);
            end
        end
        if (resValid) begin
            owed++;
            if (outCredits == 0) begin
                mismatches++;
                $display("Mismatch at %0t: o_resValid high with no result credit", $time);
            end else begin
                outCredits--;
            end
            if (expQ.size() == 0) begin
                otherErrors++;
                $display("Extra result at %0t with no request outstanding", $time);
            end else begin
                e = expQ.pop_front();
                if (resRd !== e.rd || resData !== e.data || resWrEn !== e.wrEn ||
                    resErr !== e.err) begin
                    mismatches++;
                    $write("Mismatch at %0t: result %0d rd %0d data %h wrEn %b err %0d",
                           $time, received, resRd, resData, resWrEn, resErr);
                    $display(", expected rd %0d data %h wrEn %b err %0d",
                             e.rd, e.data, e.wrEn, e.err);
                end
            end
            received++;
        end
    endtask

    // One cycle; outputs sampled and inputs driven at the falling edge
    task automatic stepCycle(input bit mayIssue, input int creditOdds);
        logic [31:0] r;
        @(negedge clock);
        checkOutputs();
        r         = nextRand();
        resCredit = 1'b0;
        reqValid  = 1'b0;
        if (owed > 0 && int'(r[31:28]) < creditOdds) begin
            resCredit = 1'b1;                        // Pay back one result
            owed--;
            outCredits++;
        end
        if (mayIssue && issued < NREQ && prodCredits > 0 && r[27:26] != 2'b00) begin
            issueRequest();
            prodCredits--;
            issued++;
        end
    endtask

    initial begin
        arstN     = 1'b0;
        reqValid  = 1'b0;
        funct3    = '0;
        isStore   = 1'b0;
        base      = '0;
        offset    = '0;
        storeData = '0;
        rd        = '0;
        resCredit = 1'b0;
        for (int i = 0; i < MEM_BYTES; i++)
            shadow[i] = 8'h00;                       // RAM starts cleared
        repeat (16) @(posedge clock);
        @(negedge clock);
        arstN = 1'b1;

        // Credits mostly returned, then withheld, then moderate
        while (issued < NREQ)
            stepCycle(1'b1, (issued < 150) ? 12 : (issued < 250) ? 1 : 8);
        while (received < NREQ)
            stepCycle(1'b0, 8);
        repeat (4) stepCycle(1'b0, 8);               // Last o_credit pulses

        if (creditPulses != NREQ) begin
            mismatches++;
            $display("Mismatch at %0t: %0d credit pulses for %0d results", $time,
                     creditPulses, NREQ);
        end
        if (prodCredits != CREDITS || expQ.size() != 0) begin
            otherErrors++;
            $display("Run ended with %0d request credits and %0d results missing",
                     prodCredits, expQ.size());
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/lsuPkg.sv
hdl/dataRam.sv
hdl/dataMemoryAdapter.sv
hdl/stageMem.sv
hdl/lsuDecode.sv
hdl/lsuExecute.sv
hdl/lsuResult.sv
hdl/lsuTop.sv
bench/lsuTb.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - hdl/lsuPkg.sv
  - hdl/dataRam.sv
  - hdl/dataMemoryAdapter.sv
  - hdl/stageMem.sv
  - hdl/lsuDecode.sv
  - hdl/lsuExecute.sv
  - hdl/lsuResult.sv
  - hdl/lsuTop.sv
  - target: simulation
    files:
      - bench/lsuTb.sv
